/* Makefile */
VERILATOR   ?= verilator
TOP         ?= cpu_bus_node_tb
WAIT_CYCLES ?= 2
FILELIST    ?= verilog.f
BUILD_DIR   ?= obj_dir
VFLAGS      ?= --binary --timing --assert -Wno-fatal

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -GWAIT_CYCLES=$(WAIT_CYCLES) \
		-Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)

/* bus_controller.sv */
`timescale 1ns/10ps

module bus_controller (
    input  logic           clk,
    input  logic           reset,
    input  logic           cpu_halt,
    input  logic           bus_req,
    input  logic           data_out,
    input  bus_pkg::addr_t cpu_addr,
    input  logic           cpu_we,
    input  bus_pkg::word_t cpu_wdata,
    input  logic           host_req,
    input  logic           host_we,
    input  bus_pkg::addr_t host_addr,
    input  bus_pkg::word_t host_wdata,
    input  bus_pkg::word_t slave_rdata,
    input  logic           dmem_busy,
    input  bus_pkg::word_t dmem_rdata,
    output logic           bus_ack,
    output logic           bus_we,
    output logic           bus_wait,
    output bus_pkg::word_t bus_rdata,
    output bus_pkg::addr_t slave_addr,
    output bus_pkg::word_t slave_wdata,
    output bus_pkg::word_t host_rdata,
    output logic           host_done,
    output logic           dmem_start,
    output logic           dmem_we,
    output bus_pkg::addr_t dmem_addr,
    output bus_pkg::word_t dmem_wdata
);
    import bus_pkg::*;

    typedef enum logic [2:0] {
        ctl_idle,
        ctl_master_addr,
        ctl_master_start,
        ctl_master_busy,
        ctl_host_xfer
    } ctl_state_e;

    ctl_state_e state;
    ctl_state_e next_state;
    ctl_state_e grant_state;
    logic       free;
    logic       master_grant;
    logic       host_grant;
    logic [1:0] host_cnt;
    addr_t      addr_q;
    logic       we_q;
    logic       host_we_q;
    word_t      host_wdata_q;

    // The bus frees up once the CPU side drops its data phase.
    assign free         = (state == ctl_idle) || (state == ctl_master_busy && !data_out);
    assign master_grant = free && bus_req && !cpu_halt;
    assign host_grant   = free && host_req && cpu_halt && !bus_req;

    assign grant_state = master_grant ? ctl_master_addr :
                         host_grant   ? ctl_host_xfer   : ctl_idle;

    always_comb begin
        next_state = state;
        case (state)
            ctl_idle:         next_state = grant_state;
            ctl_master_addr:  next_state = ctl_master_start;
            ctl_master_start: next_state = ctl_master_busy;
            ctl_master_busy: begin
                if (!data_out) begin
                    next_state = grant_state;
                end
            end
            ctl_host_xfer: begin
                if (host_cnt == 2'd2) begin
                    next_state = ctl_idle;
                end
            end
            default:          next_state = ctl_idle;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state    <= ctl_idle;
            host_cnt <= 2'd0;
        end else begin
            state <= next_state;
            if (host_grant) begin
                host_cnt <= 2'd0;
            end else if (state == ctl_host_xfer) begin
                host_cnt <= host_cnt + 2'd1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (state == ctl_master_addr) begin
            addr_q <= cpu_addr;
            we_q   <= cpu_we;
        end
        if (host_grant) begin
            host_we_q    <= host_we;
            host_wdata_q <= host_wdata;
        end
        // Instruction memory drives the word in the second cycle after the grant.
        if (state == ctl_host_xfer && host_cnt == 2'd1 && !host_we_q) begin
            host_rdata <= slave_rdata;
        end
    end

    assign bus_ack   = master_grant || host_grant;
    assign bus_we    = host_grant && host_we;
    assign bus_wait  = dmem_busy && (state == ctl_master_start || state == ctl_master_busy);
    assign bus_rdata = dmem_rdata;

    assign slave_addr  = host_addr;
    assign slave_wdata = host_wdata_q;
    assign host_done   = (state == ctl_host_xfer) && (host_cnt == 2'd2);

    assign dmem_start = (state == ctl_master_start);
    assign dmem_we    = we_q;
    assign dmem_addr  = addr_q;
    assign dmem_wdata = cpu_wdata;

    a_no_overlap: assert property (@(posedge clk) disable iff (reset)
        (state == ctl_host_xfer) |-> (!bus_req && !data_out && !dmem_busy));

endmodule

/* bus_pkg.sv */
package bus_pkg;

    // One address and one data word per bus transfer.
    parameter int ADDR_W = 8;
    parameter int DATA_W = 16;

    typedef logic [ADDR_W-1:0] addr_t;
    typedef logic [DATA_W-1:0] word_t;

    // States of the CPU side of the bus.
    // Master states serve memops; slave states serve host access to instruction memory.
    typedef enum logic [3:0] {
        st_idle,
        st_master_req,
        st_master_addr,
        st_master_wait,
        st_master_data,
        st_master_finish,
        st_slave_read_wait,
        st_slave_write_wait,
        st_slave_read,
        st_slave_write,
        st_slave_finish
    } cpu_bus_state_e;

endpackage

/* cpu_bus_interface.sv */
`timescale 1ns/10ps

module cpu_bus_interface (
    input  logic           clk,
    input  logic           reset,
    input  logic           memop,
    input  logic           mem_we,
    input  bus_pkg::addr_t mem_addr,
    input  bus_pkg::word_t mem_wdata,
    input  logic           bus_ack,
    input  logic           bus_we,
    input  logic           bus_wait,
    input  bus_pkg::word_t bus_rdata,
    output logic           bus_req,
    output logic           pc_stall,
    output logic           data_out,
    output logic           imem_out,
    output logic           imem_we,
    output logic           sel_pc,
    output logic           bus_addr_write,
    output bus_pkg::addr_t cpu_addr,
    output logic           cpu_we,
    output bus_pkg::word_t cpu_wdata,
    output bus_pkg::word_t mem_rdata
);
    import bus_pkg::*;

    cpu_bus_state_e state;
    cpu_bus_state_e next_state;
    logic           pc_stall_en;
    addr_t          req_addr;
    logic           req_we;
    word_t          req_wdata;

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= st_idle;
        end else begin
            state <= next_state;
        end
    end

    // A grant that arrives in idle can only come from the host side.
    always_comb begin
        next_state = state;
        case (state)
            st_idle: begin
                if (bus_ack) begin
                    next_state = bus_we ? st_slave_write_wait : st_slave_read_wait;
                end else if (memop) begin
                    next_state = st_master_req;
                end
            end
            st_master_req: begin
                if (bus_ack) begin
                    next_state = st_master_addr;
                end
            end
            st_master_addr:      next_state = st_master_wait;
            st_master_wait: begin
                if (!bus_wait) begin
                    next_state = st_master_data;
                end
            end
            st_master_data:      next_state = st_master_finish;
            st_master_finish:    next_state = st_idle;
            st_slave_read_wait:  next_state = st_slave_read;
            st_slave_write_wait: next_state = st_slave_write;
            st_slave_read:       next_state = st_slave_finish;
            st_slave_write:      next_state = st_slave_finish;
            default:             next_state = st_idle;
        endcase
    end

    always_comb begin
        bus_req        = 1'b0;
        pc_stall_en    = 1'b0;
        data_out       = 1'b0;
        imem_we        = 1'b0;
        imem_out       = 1'b0;
        sel_pc         = 1'b1;
        bus_addr_write = 1'b0;
        case (state)
            st_idle: begin
                bus_addr_write = bus_ack;
            end
            st_master_req, st_master_addr: begin
                bus_req     = 1'b1;
                pc_stall_en = 1'b1;
            end
            st_master_wait: begin
                bus_req     = 1'b1;
                pc_stall_en = 1'b1;
                data_out    = 1'b1;
            end
            st_master_data: begin
                pc_stall_en = 1'b1;
                data_out    = 1'b1;
            end
            st_master_finish: begin
                data_out = 1'b1;
            end
            st_slave_read: begin
                sel_pc   = 1'b0;
                imem_out = 1'b1;
            end
            st_slave_write: begin
                sel_pc  = 1'b0;
                imem_we = 1'b1;
            end
            st_slave_read_wait, st_slave_write_wait, st_slave_finish: begin
                sel_pc = 1'b0;
            end
            default: begin
                sel_pc = 1'b1;
            end
        endcase
    end

    // The pc has to stop in the same cycle the memop shows up.
    assign pc_stall = (memop && state == st_idle) || pc_stall_en;

    always_ff @(posedge clk) begin
        if (state == st_idle && memop) begin
            req_addr  <= mem_addr;
            req_we    <= mem_we;
            req_wdata <= mem_wdata;
        end
        if (state == st_master_data) begin
            mem_rdata <= bus_rdata;
        end
    end

    assign cpu_addr  = req_addr;
    assign cpu_we    = req_we;
    assign cpu_wdata = data_out ? req_wdata : '0;

    a_ack_only_when_ready: assert property (@(posedge clk) disable iff (reset)
        bus_ack |-> (state == st_idle || state == st_master_req));

    // A wait that is still high outside master_wait means the state left too early.
    a_hold_during_wait: assert property (@(posedge clk) disable iff (reset)
        bus_wait |-> state == st_master_wait);

endmodule

/* cpu_bus_node.sv */
`timescale 1ns/10ps

module cpu_bus_node #(
    parameter int WAIT_CYCLES = 2
) (
    input  logic           clk,
    input  logic           reset,
    input  logic           cpu_halt,
    input  logic           memop,
    input  logic           mem_we,
    input  bus_pkg::addr_t mem_addr,
    input  bus_pkg::word_t mem_wdata,
    input  bus_pkg::addr_t pc,
    input  logic           host_req,
    input  logic           host_we,
    input  bus_pkg::addr_t host_addr,
    input  bus_pkg::word_t host_wdata,
    output bus_pkg::word_t mem_rdata,
    output logic           pc_stall,
    output bus_pkg::word_t instr,
    output bus_pkg::word_t host_rdata,
    output logic           host_done
);
    import bus_pkg::*;

    logic  bus_req;
    logic  data_out;
    logic  imem_out;
    logic  imem_we;
    logic  sel_pc;
    logic  bus_addr_write;
    addr_t cpu_addr;
    logic  cpu_we;
    word_t cpu_wdata;
    logic  bus_ack;
    logic  bus_we;
    logic  bus_wait;
    word_t bus_rdata;
    addr_t slave_addr;
    word_t slave_wdata;
    word_t slave_rdata;
    logic  dmem_start;
    logic  dmem_we;
    logic  dmem_busy;
    addr_t dmem_addr;
    word_t dmem_wdata;
    word_t dmem_rdata;

    cpu_bus_interface cpu_bus_interface_inst (
        .clk(clk), .reset(reset), .memop(memop), .mem_we(mem_we), .mem_addr(mem_addr),
        .mem_wdata(mem_wdata), .bus_ack(bus_ack), .bus_we(bus_we), .bus_wait(bus_wait),
        .bus_rdata(bus_rdata), .bus_req(bus_req), .pc_stall(pc_stall), .data_out(data_out),
        .imem_out(imem_out), .imem_we(imem_we), .sel_pc(sel_pc),
        .bus_addr_write(bus_addr_write), .cpu_addr(cpu_addr), .cpu_we(cpu_we),
        .cpu_wdata(cpu_wdata), .mem_rdata(mem_rdata)
    );

    bus_controller bus_controller_inst (
        .clk(clk), .reset(reset), .cpu_halt(cpu_halt), .bus_req(bus_req),
        .data_out(data_out), .cpu_addr(cpu_addr), .cpu_we(cpu_we), .cpu_wdata(cpu_wdata),
        .host_req(host_req), .host_we(host_we), .host_addr(host_addr),
        .host_wdata(host_wdata), .slave_rdata(slave_rdata), .dmem_busy(dmem_busy),
        .dmem_rdata(dmem_rdata), .bus_ack(bus_ack), .bus_we(bus_we), .bus_wait(bus_wait),
        .bus_rdata(bus_rdata), .slave_addr(slave_addr), .slave_wdata(slave_wdata),
        .host_rdata(host_rdata), .host_done(host_done), .dmem_start(dmem_start),
        .dmem_we(dmem_we), .dmem_addr(dmem_addr), .dmem_wdata(dmem_wdata)
    );

    data_mem #(.WAIT_CYCLES(WAIT_CYCLES)) data_mem_inst (
        .clk(clk), .reset(reset), .start(dmem_start), .we(dmem_we), .addr(dmem_addr),
        .wdata(dmem_wdata), .busy(dmem_busy), .rdata(dmem_rdata)
    );

    instr_mem instr_mem_inst (
        .clk(clk), .pc(pc), .sel_pc(sel_pc), .bus_addr_write(bus_addr_write),
        .bus_addr(slave_addr), .imem_we(imem_we), .imem_out(imem_out),
        .bus_wdata(slave_wdata), .instr(instr), .slave_rdata(slave_rdata)
    );

endmodule

/* cpu_bus_node_tb.sv */
`timescale 1ns/10ps

module cpu_bus_node_tb #(
    parameter int WAIT_CYCLES = 2
);
    import bus_pkg::*;

    localparam int TIMEOUT     = 100;
    localparam int HOST_CYCLES = 3;
    localparam int DEPTH       = 1 << ADDR_W;

    logic  clk;
    logic  reset;
    logic  cpu_halt;
    logic  memop;
    logic  mem_we;
    addr_t mem_addr;
    word_t mem_wdata;
    addr_t pc;
    logic  host_req;
    logic  host_we;
    addr_t host_addr;
    word_t host_wdata;
    word_t mem_rdata;
    logic  pc_stall;
    word_t instr;
    word_t host_rdata;
    logic  host_done;

    word_t       imem_model [0:DEPTH-1];
    word_t       dmem_model [0:DEPTH-1];
    logic [31:0] rng;

    cpu_bus_node #(.WAIT_CYCLES(WAIT_CYCLES)) cpu_bus_node_inst (
        .clk(clk), .reset(reset), .cpu_halt(cpu_halt), .memop(memop), .mem_we(mem_we),
        .mem_addr(mem_addr), .mem_wdata(mem_wdata), .pc(pc), .host_req(host_req),
        .host_we(host_we), .host_addr(host_addr), .host_wdata(host_wdata),
        .mem_rdata(mem_rdata), .pc_stall(pc_stall), .instr(instr),
        .host_rdata(host_rdata), .host_done(host_done)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic next_random(output logic [31:0] value);
        rng = xorshift32(rng);
        value = rng;
    endtask

    task automatic check(input logic [31:0] actual, input logic [31:0] expected,
                         input string what);
        if (actual !== expected) begin
            $display("Error at %0t ns: %s is %0h, expected %0h", $time, what, actual, expected);
            $display("sim failed");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic timeout_fail(input string what);
        $display("Timed out at %0t ns while waiting for %s", $time, what);
        $display("sim failed");
        $fatal(1, "timeout");
    endtask

    // Cycle 0 is the cycle in which host_req is high.
    task automatic host_transfer(input logic we, input addr_t addr, input word_t wdata);
        int cycles;
        @(posedge clk);
        host_req   <= 1'b1;
        host_we    <= we;
        host_addr  <= addr;
        host_wdata <= wdata;
        @(posedge clk);
        host_req <= 1'b0;
        cycles = 1;
        @(negedge clk);
        while (!host_done) begin
            if (cycles >= TIMEOUT) begin
                timeout_fail("host_done");
            end
            @(negedge clk);
            cycles++;
        end
        check(32'(cycles), 32'(HOST_CYCLES), "host_done latency");
        if (we) begin
            imem_model[addr] = wdata;
        end else begin
            check(32'(host_rdata), 32'(imem_model[addr]), "host_rdata");
        end
    endtask

    task automatic check_fetch(input addr_t addr);
        @(posedge clk);
        pc <= addr;
        @(negedge clk);
        check(32'(instr), 32'(imem_model[addr]), "instr");
    endtask

    // Returns at the rising edge that ends the memop cycle.
    task automatic issue_memop(input logic we, input addr_t addr, input word_t wdata);
        @(posedge clk);
        memop     <= 1'b1;
        mem_we    <= we;
        mem_addr  <= addr;
        mem_wdata <= wdata;
        @(negedge clk);
        check(32'(pc_stall), 32'd1, "pc_stall in memop cycle");
        @(posedge clk);
        memop <= 1'b0;
    endtask

    // The cycle just before the call counts as cycle 0 of the transfer.
    task automatic finish_memop(input logic we, input addr_t addr, input word_t wdata);
        int cycles;
        cycles = 1;
        @(negedge clk);
        while (pc_stall) begin
            if (cycles >= TIMEOUT) begin
                timeout_fail("pc_stall to fall");
            end
            @(negedge clk);
            cycles++;
        end
        check(32'(cycles), 32'(WAIT_CYCLES + 5), "pc_stall latency");
        if (we) begin
            dmem_model[addr] = wdata;
        end else begin
            check(32'(mem_rdata), 32'(dmem_model[addr]), "mem_rdata");
        end
    endtask

    task automatic run_memop(input logic we, input addr_t addr, input word_t wdata);
        issue_memop(we, addr, wdata);
        finish_memop(we, addr, wdata);
    endtask

    // The last halted cycle stands in for the memop cycle once the halt is dropped.
    task automatic halted_memop(input logic we, input addr_t addr, input word_t wdata,
                                input int hold);
        @(posedge clk);
        cpu_halt <= 1'b1;
        issue_memop(we, addr, wdata);
        repeat (hold) begin
            @(negedge clk);
            check(32'(pc_stall), 32'd1, "pc_stall while halted");
            @(posedge clk);
        end
        cpu_halt <= 1'b0;
        finish_memop(we, addr, wdata);
    endtask

    initial begin
        logic [31:0] r;
        logic [31:0] d;
        rng        = 32'h1598;
        reset      = 1'b1;
        cpu_halt   = 1'b0;
        memop      = 1'b0;
        mem_we     = 1'b0;
        mem_addr   = '0;
        mem_wdata  = '0;
        pc         = '0;
        host_req   = 1'b0;
        host_we    = 1'b0;
        host_addr  = '0;
        host_wdata = '0;
        repeat (4) @(posedge clk);
        reset <= 1'b0;

        repeat (8) begin
            @(negedge clk);
            check(32'(pc_stall), 32'd0, "pc_stall while idle");
            check(32'(host_done), 32'd0, "host_done while idle");
        end

        // Host loads the whole instruction memory, then overwrites and reads back.
        @(posedge clk);
        cpu_halt <= 1'b1;
        for (int a = 0; a < DEPTH; a++) begin
            next_random(r);
            host_transfer(1'b1, addr_t'(a), r[DATA_W-1:0]);
        end
        repeat (64) begin
            next_random(r);
            next_random(d);
            host_transfer(1'b1, r[ADDR_W-1:0], d[DATA_W-1:0]);
        end
        repeat (64) begin
            next_random(r);
            host_transfer(1'b0, r[ADDR_W-1:0], '0);
        end

        @(posedge clk);
        cpu_halt <= 1'b0;
        repeat (64) begin
            next_random(r);
            check_fetch(r[ADDR_W-1:0]);
        end

        for (int a = 0; a < DEPTH; a++) begin
            next_random(r);
            run_memop(1'b1, addr_t'(a), r[DATA_W-1:0]);
        end
        repeat (128) begin
            next_random(r);
            next_random(d);
            run_memop(r[31], r[ADDR_W-1:0], d[DATA_W-1:0]);
        end

        repeat (8) begin
            next_random(r);
            next_random(d);
            halted_memop(r[31], r[ADDR_W-1:0], d[DATA_W-1:0], 1 + int'(r[19:16]));
            run_memop(1'b0, r[ADDR_W-1:0], '0);
        end

        $display("sim passed");
        $finish;
    end

endmodule

/* data_mem.sv */
`timescale 1ns/10ps

module data_mem #(
    parameter int WAIT_CYCLES = 2
) (
    input  logic           clk,
    input  logic           reset,
    input  logic           start,
    input  logic           we,
    input  bus_pkg::addr_t addr,
    input  bus_pkg::word_t wdata,
    output logic           busy,
    output bus_pkg::word_t rdata
);
    import bus_pkg::*;

    localparam int CNT_W = $clog2(WAIT_CYCLES + 1);

    logic [CNT_W-1:0] count;
    word_t            mem [0:(1 << ADDR_W) - 1];

    // The start cycle is the first busy cycle, so the counter covers the rest.
    always_ff @(posedge clk) begin
        if (reset) begin
            count <= '0;
        end else if (start) begin
            count <= CNT_W'(WAIT_CYCLES - 1);
        end else if (count != '0) begin
            count <= count - 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            if (we) begin
                mem[addr] <= wdata;
            end else begin
                rdata <= mem[addr];
            end
        end
    end

    assign busy = start || (count != '0);

    a_start_when_free: assert property (@(posedge clk) disable iff (reset)
        start |-> (count == '0));

    initial begin
        assert (WAIT_CYCLES >= 1);
    end

endmodule

/* instr_mem.sv */
`timescale 1ns/10ps

module instr_mem (
    input  logic           clk,
    input  bus_pkg::addr_t pc,
    input  logic           sel_pc,
    input  logic           bus_addr_write,
    input  bus_pkg::addr_t bus_addr,
    input  logic           imem_we,
    input  logic           imem_out,
    input  bus_pkg::word_t bus_wdata,
    output bus_pkg::word_t instr,
    output bus_pkg::word_t slave_rdata
);
    import bus_pkg::*;

    addr_t bus_addr_q;
    addr_t rd_addr;
    word_t rd_word;
    word_t mem [0:(1 << ADDR_W) - 1];

    // The host address is taken once at the grant and held for the whole transfer.
    always_ff @(posedge clk) begin
        if (bus_addr_write) begin
            bus_addr_q <= bus_addr;
        end
    end

    always_ff @(posedge clk) begin
        if (imem_we) begin
            mem[bus_addr_q] <= bus_wdata;
        end
    end

    assign rd_addr = sel_pc ? pc : bus_addr_q;
    assign rd_word = mem[rd_addr];
    assign instr   = rd_word;

    // Only drive the shared read lines during a slave read.
    assign slave_rdata = imem_out ? rd_word : '0;

endmodule

/* verilog.f */
bus_pkg.sv
cpu_bus_interface.sv
bus_controller.sv
data_mem.sv
instr_mem.sv
cpu_bus_node.sv
cpu_bus_node_tb.sv
